/* Makefile */
# Verilator build and run for the loop offload engine

VERILATOR = verilator
TOP       = loop_engine_tb
FILELIST  = sim.f
FLAGS     = --binary --timing --assert -Wno-fatal
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/loop_engine_checker.sv */
/*
 * Loop engine protocol checker
 * Credit rules on the lane channels and the done and busy handshake
 */
`timescale 1ns/1ps

module loop_engine_checker #(
    parameter int NUM_LANES    = 4,
    parameter int LANE_DEPTH   = 2,
    parameter int RESULT_DEPTH = 2
) (
    input logic                 clock,
    input logic                 rstn,
    input logic [NUM_LANES-1:0] idx_valid,
    input logic [NUM_LANES-1:0] idx_credit,
    input logic [NUM_LANES-1:0] res_valid,
    input logic [NUM_LANES-1:0] res_credit,
    input logic                 busy,
    input logic                 done
);

    localparam int ICW = $clog2(LANE_DEPTH + 1);
    localparam int RCW = $clog2(RESULT_DEPTH + 1);

    logic [ICW-1:0] idx_cred [NUM_LANES];
    logic [RCW-1:0] res_cred [NUM_LANES];
    // Number of assertion failures so far
    int             fail_count = 0;

    // Shadow credit counters per lane
    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                idx_cred[k] <= ICW'(LANE_DEPTH);
                res_cred[k] <= RCW'(RESULT_DEPTH);
            end
        end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
                idx_cred[k] <= idx_cred[k] + ICW'(idx_credit[k]) - ICW'(idx_valid[k]);
                res_cred[k] <= res_cred[k] + RCW'(res_credit[k]) - RCW'(res_valid[k]);
            end
        end
    end

    // ----------------------------------------
    // Credit rules
    // ----------------------------------------
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane_chk
        a_idx_credit: assert property (@(posedge clock) disable iff (!rstn)
            idx_valid[k] |-> (idx_cred[k] != '0))
            else begin
                fail_count++;
                $error("Lane %0d got an index with no credit left", k);
            end

        a_res_credit: assert property (@(posedge clock) disable iff (!rstn)
            res_valid[k] |-> (res_cred[k] != '0))
            else begin
                fail_count++;
                $error("Lane %0d sent a result with no credit left", k);
            end

        // Nothing outstanding means nothing to return
        a_idx_return: assert property (@(posedge clock) disable iff (!rstn)
            idx_credit[k] |-> (idx_cred[k] != ICW'(LANE_DEPTH)))
            else begin
                fail_count++;
                $error("Lane %0d returned an index credit it never spent", k);
            end
    end

    // ----------------------------------------
    // Completion handshake
    // ----------------------------------------
    a_done_busy: assert property (@(posedge clock) disable iff (!rstn)
        done |-> busy)
        else begin
            fail_count++;
            $error("done pulsed while busy was low");
        end

    a_busy_drop: assert property (@(posedge clock) disable iff (!rstn)
        done |=> !busy)
        else begin
            fail_count++;
            $error("busy still high in the cycle after done");
        end

endmodule

bind loop_engine_top loop_engine_checker #(
    .NUM_LANES   (NUM_LANES),
    .LANE_DEPTH  (LANE_DEPTH),
    .RESULT_DEPTH(RESULT_DEPTH)
) u_checker (
    .clock     (clock),
    .rstn      (rstn),
    .idx_valid (idx_valid),
    .idx_credit(idx_credit),
    .res_valid (res_valid),
    .res_credit(res_credit),
    .busy      (busy),
    .done      (done)
);

/* dv/loop_engine_tb.sv */
/*
 * Loop engine testbench
 * Runs the loops listed in the stimulus file and checks count and sum
 */
`timescale 1ns/1ps

module loop_engine_tb import loop_pkg::*; #(
    parameter int NUM_LANES    = 4,
    parameter int LANE_DEPTH   = 2,
    parameter int RESULT_DEPTH = 2
) ();

    localparam int    CLK_PERIOD       = 20;
    localparam int    RESET_CYCLES     = 10;
    localparam int    MAX_GAP          = 5;
    // One full lane turn per index, even with a single lane working
    localparam int    CYCLES_PER_INDEX = 40;
    localparam int    LOOP_OVERHEAD    = 64;
    localparam int    MARGIN_CYCLES    = 200;
    localparam string STIM_FILE        = "dv/loop_stimulus.txt";

    logic   clock;
    logic   rstn;
    logic   start;
    index_t start_index;
    index_t end_index;
    index_t displacement;
    logic   busy;
    logic   done;
    sum_t   result_sum;
    count_t result_count;

    index_t          stim_start [$];
    index_t          stim_end [$];
    index_t          stim_disp [$];
    count_t          exp_count [$];
    sum_t            exp_sum [$];
    int              error_count;
    int              check_count;
    longint unsigned timeout_ns;
    logic            timeout_armed = 1'b0;

    loop_engine_top #(
        .NUM_LANES   (NUM_LANES),
        .LANE_DEPTH  (LANE_DEPTH),
        .RESULT_DEPTH(RESULT_DEPTH)
    ) u_dut (
        .clock       (clock),
        .rstn        (rstn),
        .start       (start),
        .start_index (start_index),
        .end_index   (end_index),
        .displacement(displacement),
        .busy        (busy),
        .done        (done),
        .result_sum  (result_sum),
        .result_count(result_count)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic load_stimulus();
        int     fd;
        int     fields;
        string  line;
        index_t s;
        index_t e;
        index_t d;
        count_t c;
        sum_t   sum;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    // Skip blank lines and column notes
                    if (line.len() > 1 && line.getc(0) != "#") begin
                        fields = $sscanf(line, "%h %h %h %d %h", s, e, d, c, sum);
                        if (fields == 5) begin
                            stim_start.push_back(s);
                            stim_end.push_back(e);
                            stim_disp.push_back(d);
                            exp_count.push_back(c);
                            exp_sum.push_back(sum);
                        end else begin
                            error_count++;
                            $display("Stimulus line could not be parsed: %s", line);
                        end
                    end
                end
            end
            $fclose(fd);
            if (stim_start.size() == 0) begin
                error_count++;
                $display("The stimulus file holds no loops");
            end
        end
    endtask

    function automatic longint unsigned watchdog_limit_ns();
        longint unsigned cycles;
        cycles = RESET_CYCLES + MARGIN_CYCLES;
        foreach (exp_count[n]) begin
            cycles += longint'(exp_count[n]) * CYCLES_PER_INDEX + LOOP_OVERHEAD + MAX_GAP;
        end
        return cycles * CLK_PERIOD;
    endfunction

    // One loop from start pulse to done, then the idle check after it
    task automatic run_loop(input int n, input int gap);
        repeat (gap) @(posedge clock);
        @(negedge clock);
        check_value("busy", 64'd0, 64'(busy));
        @(posedge clock);
        start        <= 1'b1;
        start_index  <= stim_start[n];
        end_index    <= stim_end[n];
        displacement <= stim_disp[n];
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        check_value("busy", 64'd1, 64'(busy));
        while (!done) begin
            @(negedge clock);
        end
        check_value("result_count", 64'(exp_count[n]), 64'(result_count));
        check_value("result_sum", exp_sum[n], result_sum);
        @(negedge clock);
        check_value("busy", 64'd0, 64'(busy));
        // Results hold after done
        check_value("result_count", 64'(exp_count[n]), 64'(result_count));
        check_value("result_sum", exp_sum[n], result_sum);
    endtask

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin : watchdog
        wait (timeout_armed);
        #(timeout_ns);
        $display("Timeout after %0d ns, the engine never finished all loops", timeout_ns);
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main
        int gap;
        clock        = 1'b0;
        rstn         = 1'b0;
        start        = 1'b0;
        start_index  = '0;
        end_index    = '0;
        displacement = '0;
        error_count  = 0;
        check_count  = 0;
        void'($urandom(32'h4cc1));

        load_stimulus();
        timeout_ns    = watchdog_limit_ns();
        timeout_armed = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        rstn <= 1'b1;
        @(negedge clock);
        check_value("busy", 64'd0, 64'(busy));
        check_value("done", 64'd0, 64'(done));
        check_value("result_count", 64'd0, 64'(result_count));
        check_value("result_sum", 64'd0, result_sum);

        for (int n = 0; n < stim_start.size(); n++) begin
            gap = int'($urandom % (MAX_GAP + 1));
            run_loop(n, gap);
        end

        // Protocol assertion failures count as errors too
        error_count += u_dut.u_checker.fail_count;
        $display("Loops: %0d, checks: %0d, assertion failures: %0d, errors: %0d",
                 stim_start.size(), check_count, u_dut.u_checker.fail_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dv/loop_stimulus.txt */
# start end displacement (hex), expected count (decimal), expected sum (hex)
# Expected sum adds the square of every index modulo 2**64
00000003 0000000a 00000001 8   000000000000017c
00000014 0000000a 00000001 0   0000000000000000
00000000 000000c7 00000001 200 00000000002862ac
10000000 ffffffff 40000000 4   1400000000000000
fffffffc ffffffff 00000001 4   ffffffec0000001e
00000005 00000064 00000007 14  000000000000b703
00001234 00001234 00000005 1   00000000014b5a90
ffffffff 00000000 00000001 0   0000000000000000
80000000 f0000000 80000000 1   4000000000000000
00000001 00000004 00000001 4   000000000000001e

/* hw/fifo.sv */
/*
 * Synchronous FIFO, circular buffer with occupancy counter
 * First-word-fall-through read port
 */
`timescale 1ns/1ps

module fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             rstn,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             full,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    // Requests against a full or empty buffer are dropped
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

/* hw/loop_body_lane.sv */
/*
 * Loop body lane
 * Queues indices and squares each with a 32-step shift-add multiplier
 */
`timescale 1ns/1ps

module loop_body_lane import loop_pkg::*; #(
    parameter int LANE_DEPTH   = 2,
    parameter int RESULT_DEPTH = 2
) (
    input  logic    clock,
    input  logic    rstn,
    input  logic    idx_valid,
    input  index_t  idx_data,
    input  logic    res_credit,
    output logic    idx_credit,
    output logic    res_valid,
    output result_t res_data
);

    localparam int QAW = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
    localparam int QCW = $clog2(LANE_DEPTH + 1);
    localparam int RCW = $clog2(RESULT_DEPTH + 1);

    lane_state_e    state;
    index_t         q_mem [LANE_DEPTH];
    logic [QAW-1:0] q_wr;
    logic [QAW-1:0] q_rd;
    logic [QCW-1:0] q_occ;
    logic [RCW-1:0] res_cred;
    logic [4:0]     step;
    logic           take;
    result_t        acc;
    result_t        mcand;
    index_t         mplier;
    result_t        acc_src;
    result_t        mcand_src;
    index_t         mplier_src;
    result_t        acc_nxt;

    // ----------------------------------------
    // Input queue
    // ----------------------------------------
    // Space is guaranteed by the generator's credits
    assign take       = (state == WAIT) && (q_occ != '0);
    assign idx_credit = take;

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            q_wr  <= '0;
            q_rd  <= '0;
            q_occ <= '0;
        end else begin
            if (idx_valid) begin
                q_wr <= (q_wr == QAW'(LANE_DEPTH - 1)) ? '0 : q_wr + 1'b1;
            end
            if (take) begin
                q_rd <= (q_rd == QAW'(LANE_DEPTH - 1)) ? '0 : q_rd + 1'b1;
            end
            q_occ <= q_occ + QCW'(idx_valid) - QCW'(take);
        end
    end

    always_ff @(posedge clock) begin
        if (idx_valid) begin
            q_mem[q_wr] <= idx_data;
        end
    end

    // ----------------------------------------
    // Shift-add squarer
    // ----------------------------------------
    // First step runs in the take cycle straight off the queue head
    always_comb begin
        if (state == WAIT) begin
            acc_src    = '0;
            mcand_src  = {32'b0, q_mem[q_rd]};
            mplier_src = q_mem[q_rd];
        end else begin
            acc_src    = acc;
            mcand_src  = mcand;
            mplier_src = mplier;
        end
        acc_nxt = mplier_src[0] ? acc_src + mcand_src : acc_src;
    end

    always_ff @(posedge clock) begin
        if (take || (state == MULT)) begin
            acc    <= acc_nxt;
            mcand  <= mcand_src << 1;
            mplier <= mplier_src >> 1;
        end
    end

    assign res_valid = (state == SEND) && (res_cred != '0);
    assign res_data  = acc;

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            state    <= WAIT;
            step     <= '0;
            res_cred <= RCW'(RESULT_DEPTH);
        end else begin
            case (state)
                WAIT: begin
                    if (take) begin
                        step  <= 5'd1;
                        state <= MULT;
                    end
                end
                MULT: begin
                    step <= step + 1'b1;
                    // Step 32 lands here
                    if (step == 5'd31) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (res_valid) begin
                        state <= WAIT;
                    end
                end
                default: state <= WAIT;
            endcase
            res_cred <= res_cred + RCW'(res_credit) - RCW'(res_valid);
        end
    end

endmodule

/* hw/loop_engine_top.sv */
/*
 * Loop offload engine top level
 * Generator, lane array and result collector
 */
`timescale 1ns/1ps

module loop_engine_top import loop_pkg::*; #(
    parameter int NUM_LANES    = 4,
    parameter int LANE_DEPTH   = 2,
    parameter int RESULT_DEPTH = 2
) (
    input  logic   clock,
    input  logic   rstn,
    input  logic   start,
    input  index_t start_index,
    input  index_t end_index,
    input  index_t displacement,
    output logic   busy,
    output logic   done,
    output sum_t   result_sum,
    output count_t result_count
);

    logic [NUM_LANES-1:0] idx_valid;
    index_t               idx_data [NUM_LANES];
    logic [NUM_LANES-1:0] idx_credit;
    logic [NUM_LANES-1:0] res_valid;
    result_t              res_data [NUM_LANES];
    logic [NUM_LANES-1:0] res_credit;
    logic                 issue_done;
    count_t               issue_count;

    loop_index_generator #(
        .NUM_LANES (NUM_LANES),
        .LANE_DEPTH(LANE_DEPTH)
    ) u_gen (
        .clock       (clock),
        .rstn        (rstn),
        .start       (start),
        .start_index (start_index),
        .end_index   (end_index),
        .displacement(displacement),
        .idx_credit  (idx_credit),
        .idx_valid   (idx_valid),
        .idx_data    (idx_data),
        .issue_done  (issue_done),
        .issue_count (issue_count)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        loop_body_lane #(
            .LANE_DEPTH  (LANE_DEPTH),
            .RESULT_DEPTH(RESULT_DEPTH)
        ) u_lane (
            .clock     (clock),
            .rstn      (rstn),
            .idx_valid (idx_valid[k]),
            .idx_data  (idx_data[k]),
            .res_credit(res_credit[k]),
            .idx_credit(idx_credit[k]),
            .res_valid (res_valid[k]),
            .res_data  (res_data[k])
        );
    end

    result_collector #(
        .NUM_LANES   (NUM_LANES),
        .RESULT_DEPTH(RESULT_DEPTH)
    ) u_col (
        .clock       (clock),
        .rstn        (rstn),
        .start       (start),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .issue_done  (issue_done),
        .issue_count (issue_count),
        .res_credit  (res_credit),
        .busy        (busy),
        .done        (done),
        .result_sum  (result_sum),
        .result_count(result_count)
    );

endmodule

/* hw/loop_index_generator.sv */
/*
 * Loop index generator
 * Walks start to end by displacement, buffers indices and deals them to lanes
 */
`timescale 1ns/1ps

module loop_index_generator import loop_pkg::*; #(
    parameter int NUM_LANES  = 4,
    parameter int LANE_DEPTH = 2
) (
    input  logic                 clock,
    input  logic                 rstn,
    input  logic                 start,
    input  index_t               start_index,
    input  index_t               end_index,
    input  index_t               displacement,
    input  logic [NUM_LANES-1:0] idx_credit,
    output logic [NUM_LANES-1:0] idx_valid,
    output index_t               idx_data [NUM_LANES],
    output logic                 issue_done,
    output count_t               issue_count
);

    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int CW = $clog2(LANE_DEPTH + 1);

    gen_state_e    state;
    index_t        cur_index;
    index_t        end_q;
    index_t        disp_q;
    logic [32:0]   next_index;
    logic          last_step;
    logic          start_ok;
    logic          push;
    logic          fifo_full;
    logic          fifo_empty;
    index_t        fifo_out;
    logic [CW-1:0] credit [NUM_LANES];
    logic [LW-1:0] rr_ptr;
    logic [LW-1:0] sel_lane;
    logic          lane_found;
    logic          dispatch;

    // ----------------------------------------
    // Loop walk
    // ----------------------------------------
    // Carry bit catches a step past 2**32
    assign next_index = {1'b0, cur_index} + {1'b0, disp_q};
    assign last_step  = next_index[32] || (next_index[31:0] > end_q);
    assign start_ok   = start && ((state == IDLE) || issue_done);
    assign push       = (state == RUN) && !fifo_full;
    assign issue_done = (state == DRAIN) && fifo_empty;

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            state       <= IDLE;
            issue_count <= '0;
        end else begin
            if (start_ok) begin
                issue_count <= '0;
                // Empty range finishes with nothing issued
                state <= (start_index > end_index) ? DRAIN : RUN;
            end else if (push) begin
                issue_count <= issue_count + 1'b1;
                if (last_step) begin
                    state <= DRAIN;
                end
            end
        end
    end

    // Loop bounds and the walking index
    always_ff @(posedge clock) begin
        if (start_ok) begin
            cur_index <= start_index;
            end_q     <= end_index;
            disp_q    <= displacement;
        end else if (push && !last_step) begin
            cur_index <= next_index[31:0];
        end
    end

    fifo #(
        .WIDTH($bits(index_t)),
        .DEPTH(8)
    ) u_index_fifo (
        .clock   (clock),
        .rstn    (rstn),
        .push    (push),
        .pop     (dispatch),
        .data_in (cur_index),
        .data_out(fifo_out),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    // ----------------------------------------
    // Round-robin dispatch
    // ----------------------------------------
    // First lane at or after rr_ptr that still holds a credit
    always_comb begin
        int unsigned cand;
        lane_found = 1'b0;
        sel_lane   = rr_ptr;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            cand = rr_ptr + i;
            if (cand >= NUM_LANES) begin
                cand = cand - NUM_LANES;
            end
            if (credit[cand] != '0) begin
                lane_found = 1'b1;
                sel_lane   = LW'(cand);
            end
        end
    end

    assign dispatch = lane_found && !fifo_empty;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            idx_valid[k] = dispatch && (sel_lane == LW'(k));
            idx_data[k]  = fifo_out;
        end
    end

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            rr_ptr <= '0;
            for (int k = 0; k < NUM_LANES; k++) begin
                credit[k] <= CW'(LANE_DEPTH);
            end
        end else begin
            if (dispatch) begin
                rr_ptr <= (sel_lane == LW'(NUM_LANES - 1)) ? '0 : sel_lane + 1'b1;
            end
            // One spent per valid cycle, one back per lane pop
            for (int k = 0; k < NUM_LANES; k++) begin
                credit[k] <= credit[k] + CW'(idx_credit[k]) - CW'(idx_valid[k]);
            end
        end
    end

endmodule

/* hw/loop_pkg.sv */
/*
 * Loop engine shared definitions
 * Data widths of the index, product, sum and count, and FSM state encodings
 */
package loop_pkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------
    // Loop index as walked by the generator
    typedef logic [31:0] index_t;

    // Square of one index
    typedef logic [63:0] result_t;

    // Accumulated sum, wraps modulo 2**64
    typedef logic [63:0] sum_t;

    // Iteration count
    typedef logic [31:0] count_t;

    // ----------------------------------------
    // FSM states
    // ----------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } gen_state_e;

    typedef enum logic [1:0] {
        WAIT,
        MULT,
        SEND
    } lane_state_e;

endpackage

/* hw/result_collector.sv */
/*
 * Result collector
 * Drains lane results round-robin, sums and counts them, flags completion
 */
`timescale 1ns/1ps

module result_collector import loop_pkg::*; #(
    parameter int NUM_LANES    = 4,
    parameter int RESULT_DEPTH = 2
) (
    input  logic                 clock,
    input  logic                 rstn,
    input  logic                 start,
    input  logic [NUM_LANES-1:0] res_valid,
    input  result_t              res_data [NUM_LANES],
    input  logic                 issue_done,
    input  count_t               issue_count,
    output logic [NUM_LANES-1:0] res_credit,
    output logic                 busy,
    output logic                 done,
    output sum_t                 result_sum,
    output count_t               result_count
);

    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    result_t                q_data [NUM_LANES];
    logic [NUM_LANES-1:0]   q_empty;
    logic [LW-1:0]          rr_ptr;
    logic [LW-1:0]          sel_lane;
    logic                   pop_any;

    // One result queue per lane, sized to its credits
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_queue
        fifo #(
            .WIDTH($bits(result_t)),
            .DEPTH(RESULT_DEPTH)
        ) u_result_fifo (
            .clock   (clock),
            .rstn    (rstn),
            .push    (res_valid[k]),
            .pop     (res_credit[k]),
            .data_in (res_data[k]),
            .data_out(q_data[k]),
            .full    (),
            .empty   (q_empty[k])
        );
    end

    // ----------------------------------------
    // Round-robin drain
    // ----------------------------------------
    always_comb begin
        int unsigned cand;
        pop_any  = 1'b0;
        sel_lane = rr_ptr;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            cand = rr_ptr + i;
            if (cand >= NUM_LANES) begin
                cand = cand - NUM_LANES;
            end
            if (!q_empty[cand]) begin
                pop_any  = 1'b1;
                sel_lane = LW'(cand);
            end
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            res_credit[k] = pop_any && (sel_lane == LW'(k));
        end
    end

    // All issued indices accounted for
    assign done = busy && issue_done && (result_count == issue_count);

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            rr_ptr       <= '0;
            busy         <= 1'b0;
            result_sum   <= '0;
            result_count <= '0;
        end else begin
            if (pop_any) begin
                rr_ptr <= (sel_lane == LW'(NUM_LANES - 1)) ? '0 : sel_lane + 1'b1;
            end
            if (start && !busy) begin
                busy         <= 1'b1;
                result_sum   <= '0;
                result_count <= '0;
            end else begin
                if (done) begin
                    busy <= 1'b0;
                end
                if (pop_any) begin
                    result_sum   <= result_sum + q_data[sel_lane];
                    result_count <= result_count + 1'b1;
                end
            end
        end
    end

endmodule

/* sim.f */
hw/loop_pkg.sv
hw/fifo.sv
hw/loop_index_generator.sv
hw/loop_body_lane.sv
hw/result_collector.sv
hw/loop_engine_top.sv
dv/loop_engine_checker.sv
dv/loop_engine_tb.sv
